// File: source/spi_bit_clock.sv
// SPI bit period phase counter
`timescale 1ns/10ps

module spi_bit_clock #(
  parameter int CLK_RATIO = 8 // Clocks per SCK period, even, at least 4
) (
  input  logic i_ext_spi_clk_x,
  input  logic i_srst,
  output logic sck_phase_o,  // Free-running SCK level
  output logic bit_start_o,  // Phase 0, falling edge
  output logic bit_sample_o  // Mid period, rising edge
);

  localparam int PH_W = $clog2(CLK_RATIO);

  logic [PH_W-1:0] phase_q; // 0 .. CLK_RATIO-1

  // Wraps continuously from reset
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      phase_q <= '0;
    end else if (phase_q == PH_W'(CLK_RATIO - 1)) begin
      phase_q <= '0; // New bit period
    end else begin
      phase_q <= phase_q + 1'b1;
    end
  end

  // Low first half, high second half
  assign sck_phase_o  = (phase_q >= PH_W'(CLK_RATIO / 2));
  assign bit_start_o  = (phase_q == '0);
  assign bit_sample_o = (phase_q == PH_W'(CLK_RATIO / 2)); // CIPO sample point

  // Odd ratio would skew the duty cycle and the sample point
  a_ratio_even: assert property (
    @(posedge i_ext_spi_clk_x)
    ((CLK_RATIO % 2) == 0) && (CLK_RATIO >= 4)
  ) else $error("CLK_RATIO must be even and at least 4");

endmodule : spi_bit_clock

// File: source/spi_bus_fsm.sv
// SPI bus transaction FSM
`timescale 1ns/10ps

module spi_bus_fsm #(
  parameter int TX_LEN_W = 4,
  parameter int RX_LEN_W = 4,
  parameter int WAIT_W   = 3
) (
  input  logic                i_ext_spi_clk_x,
  input  logic                i_srst,
  input  logic                go_i,        // Command strobe
  input  logic [TX_LEN_W-1:0] tx_len_i,    // Bytes to send, nonzero
  input  logic [RX_LEN_W-1:0] rx_len_i,    // Bytes to receive
  input  logic [WAIT_W-1:0]   wait_cyc_i,  // Wait bit periods
  input  logic                sck_phase_i,
  input  logic                bit_start_i,
  input  logic                bit_sample_i,
  output logic                idle_o,
  output logic                csn_o,
  output logic                sck_o,
  output logic                copi_o,
  output logic                rx_sample_o, // CIPO strobe for the shifter
  spi_fifo_if.reader          tx_fifo
);
  import spi_solo_pkg::*;

  localparam int LEN_W     = (TX_LEN_W > RX_LEN_W) ? TX_LEN_W : RX_LEN_W;
  localparam int BIT_IDX_W = $clog2(BYTE_BITS);
  localparam int TMR_W     = (LEN_W + BIT_IDX_W > WAIT_W) ? LEN_W + BIT_IDX_W : WAIT_W;

  ////////////////////////////////////////////////////////////
  // Command latch
  ////////////////////////////////////////////////////////////

  logic [TX_LEN_W-1:0] tx_len_q;
  logic [RX_LEN_W-1:0] rx_len_q;
  logic [WAIT_W-1:0]   wait_q;
  logic                go_pend_q; // Accepted, waiting for phase 0

  spi_state_e state_q;
  spi_state_e nx_state;

  logic go_accept;
  assign go_accept = go_i && idle_o;

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      go_pend_q <= 1'b0;
    end else if (go_accept) begin
      go_pend_q <= 1'b1;
    end else if (bit_start_i && (state_q == ST_IDLE)) begin
      go_pend_q <= 1'b0; // FSM leaves idle on this edge
    end
  end

  // Held for the whole transaction
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (go_accept) begin
      tx_len_q <= tx_len_i;
      rx_len_q <= rx_len_i;
      wait_q   <= wait_cyc_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Bit timer and state register
  ////////////////////////////////////////////////////////////

  logic [TMR_W-1:0] timer_q; // Bit periods spent in the state
  logic [TMR_W-1:0] tx_bits;
  logic [TMR_W-1:0] rx_bits;
  logic             guard_last;
  logic             byte_due; // Next falling edge starts a TX byte

  assign tx_bits    = TMR_W'(tx_len_q) * TMR_W'(BYTE_BITS);
  assign rx_bits    = TMR_W'(rx_len_q) * TMR_W'(BYTE_BITS);
  assign guard_last = (timer_q == TMR_W'(GUARD_BITS - 1));

  always_comb begin
    nx_state = state_q;
    case (state_q)
      ST_IDLE:    if (go_pend_q) nx_state = ST_START_D;
      ST_START_D: if (guard_last) nx_state = ST_START_S;
      ST_START_S: if (guard_last) nx_state = ST_TX;
      ST_TX: begin
        if (timer_q == tx_bits - 1'b1) begin
          if (rx_len_q == '0)      nx_state = ST_STOP_S;
          else if (wait_q == '0)   nx_state = ST_RX;
          else                     nx_state = ST_WAIT;
        end
      end
      ST_WAIT:    if (timer_q == TMR_W'(wait_q) - 1'b1) nx_state = ST_RX;
      ST_RX:      if (timer_q == rx_bits - 1'b1) nx_state = ST_STOP_S;
      ST_STOP_S:  if (guard_last) nx_state = ST_STOP_D;
      ST_STOP_D:  if (guard_last) nx_state = ST_IDLE;
      default:    nx_state = ST_IDLE;
    endcase
  end

  // Everything moves on the SCK falling edge only
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      state_q <= ST_IDLE;
      timer_q <= '0;
    end else if (bit_start_i) begin
      state_q <= nx_state;
      if ((nx_state != state_q) || (state_q == ST_IDLE)) timer_q <= '0;
      else                                               timer_q <= timer_q + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // TX byte fetch and COPI shift
  ////////////////////////////////////////////////////////////

  byte_t tx_sr_q;    // COPI shift register
  logic  fetch_ok_q; // Last fetch found a byte

  assign byte_due =
    ((state_q == ST_START_S) && guard_last) ||
    ((state_q == ST_TX) && (timer_q != tx_bits - 1'b1) &&
     (timer_q[BIT_IDX_W-1:0] == BIT_IDX_W'(BYTE_BITS - 1)));

  // Read mid-bit so rd_data settles before the falling edge
  assign tx_fifo.rd_en = bit_sample_i && byte_due && !tx_fifo.empty;

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      fetch_ok_q <= 1'b0;
    end else if (bit_sample_i && byte_due) begin
      fetch_ok_q <= !tx_fifo.empty; // Underrun sends zeros
    end
  end

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (bit_start_i) begin
      if (byte_due) tx_sr_q <= fetch_ok_q ? tx_fifo.rd_data : '0;
      else if (state_q == ST_TX) tx_sr_q <= {tx_sr_q[BYTE_BITS-2:0], 1'b0}; // MSB first
    end
  end

  ////////////////////////////////////////////////////////////
  // Bus outputs
  ////////////////////////////////////////////////////////////

  assign idle_o      = (state_q == ST_IDLE) && !go_pend_q;
  assign csn_o       = (state_q == ST_IDLE) || (state_q == ST_START_D) ||
                       (state_q == ST_STOP_D);
  assign sck_o       = sck_phase_i && ((state_q == ST_TX) || (state_q == ST_WAIT) ||
                                       (state_q == ST_RX)); // Parked low otherwise
  assign copi_o      = (state_q == ST_TX) && tx_sr_q[BYTE_BITS-1];
  assign rx_sample_o = bit_sample_i && (state_q == ST_RX);

  // Peripheral already deselected when the FSM lands in idle
  a_csn_idle: assert property (
    @(posedge i_ext_spi_clk_x) disable iff (i_srst)
    (state_q == ST_IDLE) |-> $past(csn_o)
  ) else $error("Idle entered while CSN low");

  // Zero TX length would leave the TX state unbounded
  a_tx_len_nonzero: assert property (
    @(posedge i_ext_spi_clk_x) disable iff (i_srst)
    go_accept |-> (tx_len_i != '0)
  ) else $error("Command with tx_len of zero");

endmodule : spi_bus_fsm

// File: source/spi_fifo_if.sv
// Byte FIFO interface
`timescale 1ns/10ps

interface spi_fifo_if;
  import spi_solo_pkg::*;

  // Write side
  logic  wr_en;   // Write strobe
  byte_t wr_data; // Byte to store
  logic  full;    // No room left

  // Read side
  logic  rd_en;   // Read strobe
  byte_t rd_data; // Valid the cycle after a read
  logic  empty;   // Nothing stored

  // The FIFO itself
  modport fifo (
    input  wr_en, wr_data, rd_en,
    output full, rd_data, empty
  );

  // Producer of bytes
  modport writer (output wr_en, wr_data, input full);

  // Consumer of bytes
  modport reader (output rd_en, input rd_data, empty);

endinterface : spi_fifo_if

// File: source/spi_rx_shifter.sv
// SPI CIPO byte assembler
`timescale 1ns/10ps

module spi_rx_shifter (
  input logic        i_ext_spi_clk_x,
  input logic        i_srst,
  input logic        cipo_i,      // Peripheral data
  input logic        rx_sample_i, // Rising edge strobe in ST_RX
  spi_fifo_if.writer rx_fifo
);
  import spi_solo_pkg::*;

  localparam int CNT_W = $clog2(BYTE_BITS);

  ////////////////////////////////////////////////////////////
  // Shift and count
  ////////////////////////////////////////////////////////////

  byte_t            rx_sr_q;  // Assembled byte, MSB first
  logic [CNT_W-1:0] bit_cnt_q; // Bits taken, modulo 8
  logic             wr_q;      // Byte complete last cycle

  // Payload only, no reset
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (rx_sample_i) begin
      rx_sr_q <= {rx_sr_q[BYTE_BITS-2:0], cipo_i};
    end
  end

  // RX phases are whole bytes, so the count never drifts
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      bit_cnt_q <= '0;
      wr_q      <= 1'b0;
    end else begin
      wr_q <= rx_sample_i && (bit_cnt_q == CNT_W'(BYTE_BITS - 1)); // Eighth bit
      if (rx_sample_i) bit_cnt_q <= bit_cnt_q + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // FIFO write
  ////////////////////////////////////////////////////////////

  // Byte stays put until the next sample, a full period away
  assign rx_fifo.wr_data = rx_sr_q;
  assign rx_fifo.wr_en   = wr_q && !rx_fifo.full; // Dropped when full

endmodule : spi_rx_shifter

// File: source/spi_solo_pkg.sv
// SPI solo shared definitions
package spi_solo_pkg;

  ////////////////////////////////////////////////////////////
  // Data path
  ////////////////////////////////////////////////////////////

  // Bits per byte on COPI, CIPO and both FIFOs
  localparam int BYTE_BITS = 8;

  // One data byte, MSB goes out first
  typedef logic [BYTE_BITS-1:0] byte_t;

  ////////////////////////////////////////////////////////////
  // Transaction framing
  ////////////////////////////////////////////////////////////

  // Bit periods spent in each of the four framing states
  localparam int GUARD_BITS = 4;

  // Bus FSM states, in transaction order
  typedef enum logic [2:0] {
    ST_IDLE,    // CSN high, waiting for a command
    ST_START_D, // Deselected lead-in
    ST_START_S, // Selected, clock still parked low
    ST_TX,      // Shifting COPI bytes out
    ST_WAIT,    // Clock runs, no data either way
    ST_RX,      // Sampling CIPO bytes
    ST_STOP_S,  // Selected tail, clock parked
    ST_STOP_D   // Deselected tail before idle
  } spi_state_e;

  // Tx FIFO fetch happens at mid-bit before the byte boundary,
  // so the read latency of one clock is hidden by the half period
  // between the sample strobe and the next falling edge

endpackage : spi_solo_pkg

// File: source/spi_solo_top.sv
// SPI solo controller top level
`timescale 1ns/10ps

module spi_solo_top #(
  parameter int CLK_RATIO  = 8,
  parameter int TX_LEN_W   = 4,
  parameter int RX_LEN_W   = 4,
  parameter int WAIT_W     = 3,
  parameter int FIFO_DEPTH = 16
) (
  input  logic                i_ext_spi_clk_x,
  input  logic                i_srst,
  // Host TX side
  input  spi_solo_pkg::byte_t tx_data_i,
  input  logic                tx_enqueue_i,
  output logic                tx_ready_o,
  // Host RX side
  input  logic                rx_dequeue_i,
  output spi_solo_pkg::byte_t rx_data_o,
  output logic                rx_valid_o, // One cycle after dequeue
  output logic                rx_avail_o,
  // Command
  input  logic                go_i,
  input  logic [TX_LEN_W-1:0] tx_len_i,
  input  logic [RX_LEN_W-1:0] rx_len_i,
  input  logic [WAIT_W-1:0]   wait_cyc_i,
  output logic                idle_o,
  // SPI bus
  output logic                sck_o,
  output logic                csn_o,
  output logic                copi_o,
  input  logic                cipo_i
);

  spi_fifo_if tx_fifo_if ();
  spi_fifo_if rx_fifo_if ();

  logic sck_phase;
  logic bit_start;
  logic bit_sample;
  logic rx_sample;
  logic rx_valid_q;

  ////////////////////////////////////////////////////////////
  // Host handshakes
  ////////////////////////////////////////////////////////////

  assign tx_fifo_if.wr_en   = tx_enqueue_i && !tx_fifo_if.full; // Gated, full drops
  assign tx_fifo_if.wr_data = tx_data_i;
  assign tx_ready_o         = !tx_fifo_if.full;

  assign rx_fifo_if.rd_en = rx_dequeue_i && !rx_fifo_if.empty; // Empty reads ignored
  assign rx_avail_o       = !rx_fifo_if.empty;
  assign rx_data_o        = rx_fifo_if.rd_data;
  assign rx_valid_o       = rx_valid_q;

  // Matches the one-cycle read latency of the FIFO
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) rx_valid_q <= 1'b0;
    else        rx_valid_q <= rx_fifo_if.rd_en;
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  spi_sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_tx_fifo (
    .i_ext_spi_clk_x, .i_srst, .fifo_if(tx_fifo_if.fifo));

  spi_sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_rx_fifo (
    .i_ext_spi_clk_x, .i_srst, .fifo_if(rx_fifo_if.fifo));

  spi_bit_clock #(.CLK_RATIO(CLK_RATIO)) u_bit_clock (
    .i_ext_spi_clk_x, .i_srst, .sck_phase_o(sck_phase),
    .bit_start_o(bit_start), .bit_sample_o(bit_sample));

  spi_bus_fsm #(.TX_LEN_W(TX_LEN_W), .RX_LEN_W(RX_LEN_W), .WAIT_W(WAIT_W)) u_bus_fsm (
    .i_ext_spi_clk_x, .i_srst, .go_i, .tx_len_i, .rx_len_i, .wait_cyc_i,
    .sck_phase_i(sck_phase), .bit_start_i(bit_start), .bit_sample_i(bit_sample),
    .idle_o, .csn_o, .sck_o, .copi_o, .rx_sample_o(rx_sample),
    .tx_fifo(tx_fifo_if.reader));

  spi_rx_shifter u_rx_shifter (
    .i_ext_spi_clk_x, .i_srst, .cipo_i, .rx_sample_i(rx_sample),
    .rx_fifo(rx_fifo_if.writer));

endmodule : spi_solo_top

// File: source/spi_sync_fifo.sv
// Synchronous byte FIFO
`timescale 1ns/10ps

module spi_sync_fifo #(
  parameter int FIFO_DEPTH = 16 // Power of two
) (
  input logic     i_ext_spi_clk_x,
  input logic     i_srst,
  spi_fifo_if.fifo fifo_if
);
  import spi_solo_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  ////////////////////////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////////////////////////

  byte_t mem [FIFO_DEPTH]; // Circular buffer

  // Extra MSB tells full from empty when the indices match
  logic [PTR_W:0] wr_ptr_q;
  logic [PTR_W:0] rd_ptr_q;

  logic do_wr; // Accepted write
  logic do_rd; // Accepted read

  assign fifo_if.empty = (wr_ptr_q == rd_ptr_q);
  assign fifo_if.full  = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
                         (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);

  assign do_wr = fifo_if.wr_en && !fifo_if.full;  // Write while full dropped
  assign do_rd = fifo_if.rd_en && !fifo_if.empty; // Read while empty ignored

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (do_wr) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_rd) rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  // Array write, no reset on the storage
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (do_wr) begin
      mem[wr_ptr_q[PTR_W-1:0]] <= fifo_if.wr_data;
    end
  end

  // Registered read port, byte holds until the next read
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (do_rd) begin
      fifo_if.rd_data <= mem[rd_ptr_q[PTR_W-1:0]];
    end
  end

  ////////////////////////////////////////////////////////////
  // Integration checks
  ////////////////////////////////////////////////////////////

  // Producers must hold off while full
  a_no_wr_when_full: assert property (
    @(posedge i_ext_spi_clk_x) disable iff (i_srst)
    !(fifo_if.wr_en && fifo_if.full)
  ) else $error("FIFO written while full");

  // Consumers must hold off while empty
  a_no_rd_when_empty: assert property (
    @(posedge i_ext_spi_clk_x) disable iff (i_srst)
    !(fifo_if.rd_en && fifo_if.empty)
  ) else $error("FIFO read while empty");

endmodule : spi_sync_fifo

// File: spi_solo.f
source/spi_solo_pkg.sv
source/spi_fifo_if.sv
source/spi_sync_fifo.sv
source/spi_bit_clock.sv
source/spi_bus_fsm.sv
source/spi_rx_shifter.sv
source/spi_solo_top.sv
tests/spi_device_model.sv
tests/spi_solo_tb.sv

// File: tests/spi_device_model.sv
// Behavioral SPI peripheral
`timescale 1ns/10ps

module spi_device_model (
  input  logic sck_i,
  input  logic csn_i,
  input  logic copi_i,
  output logic cipo_o
);
  import spi_solo_pkg::*;

  localparam int MAX_BYTES = 32;

  byte_t rec_mem [MAX_BYTES];  // COPI bytes seen, MSB first
  byte_t play_mem [MAX_BYTES]; // CIPO bytes to present
  int    rise_cnt;             // SCK rising edges while selected
  int    play_len;             // Bytes loaded for CIPO
  int    play_bit;             // Next CIPO bit index
  int    skip_bits;            // Rising edges before CIPO starts

  initial cipo_o = 1'b0;

  // New transaction, clears the log and the CIPO stream
  task automatic arm(input int skip);
    int i;
    rise_cnt  = 0;
    play_len  = 0;
    play_bit  = 0;
    skip_bits = skip;
    for (i = 0; i < MAX_BYTES; i++) rec_mem[i] = '0;
  endtask

  task automatic queue_byte(input byte_t b);
    play_mem[play_len] = b;
    play_len++;
  endtask

  function automatic byte_t rec_byte(input int idx);
    return rec_mem[idx];
  endfunction

  function automatic int rise_count();
    return rise_cnt;
  endfunction

  // 1 ns settle so zero-width SCK glitches are not taken as edges
  always @(posedge sck_i) begin
    #1;
    if (sck_i && !csn_i) begin
      rec_mem[rise_cnt / BYTE_BITS] = {rec_mem[rise_cnt / BYTE_BITS][BYTE_BITS-2:0], copi_i};
      rise_cnt++;
    end
  end

  // CIPO moves on the falling edge, half a period before the sample
  always @(negedge sck_i) begin
    #1;
    if (!sck_i && !csn_i && (rise_cnt >= skip_bits) && (play_bit < play_len * BYTE_BITS)) begin
      cipo_o <= play_mem[play_bit / BYTE_BITS][BYTE_BITS - 1 - (play_bit % BYTE_BITS)];
      play_bit++;
    end
  end

endmodule : spi_device_model

// File: tests/spi_solo_tb.sv
// SPI solo controller testbench
`timescale 1ns/10ps

module spi_solo_tb;
  import spi_solo_pkg::*;

  localparam int CLK_RATIO  = 8;
  localparam int TX_LEN_W   = 5; // Wide enough for a whole FIFO in one command
  localparam int RX_LEN_W   = 4;
  localparam int WAIT_W     = 3;
  localparam int FIFO_DEPTH = 16;
  localparam int FRAME_BITS = 4 * GUARD_BITS + 1; // Framing plus start latency

  // Bit periods of all tests, host traffic as a spare 32
  localparam int TEST_BITS = 4 * FRAME_BITS + 8 * (3 + 3 + 2 + FIFO_DEPTH) + 3 + 32;
  localparam int WATCHDOG_NS = 2 * TEST_BITS * CLK_RATIO * 20;

  logic                i_ext_spi_clk_x;
  logic                i_srst;
  byte_t               tx_data, rx_data;
  logic                tx_enqueue, tx_ready, rx_dequeue, rx_valid, rx_avail;
  logic                go, idle, sck, csn, copi, cipo;
  logic [TX_LEN_W-1:0] tx_len;
  logic [RX_LEN_W-1:0] rx_len;
  logic [WAIT_W-1:0]   wait_cyc;
  logic [15:0]         lfsr_q;   // Random state, seed 3
  int                  fail_cnt;

  spi_solo_top #(.CLK_RATIO(CLK_RATIO), .TX_LEN_W(TX_LEN_W), .RX_LEN_W(RX_LEN_W),
                 .WAIT_W(WAIT_W), .FIFO_DEPTH(FIFO_DEPTH)) i_spi_solo_top (
    .i_ext_spi_clk_x, .i_srst, .tx_data_i(tx_data), .tx_enqueue_i(tx_enqueue),
    .tx_ready_o(tx_ready), .rx_dequeue_i(rx_dequeue), .rx_data_o(rx_data),
    .rx_valid_o(rx_valid), .rx_avail_o(rx_avail), .go_i(go), .tx_len_i(tx_len),
    .rx_len_i(rx_len), .wait_cyc_i(wait_cyc), .idle_o(idle), .sck_o(sck),
    .csn_o(csn), .copi_o(copi), .cipo_i(cipo));

  spi_device_model u_dev_model (.sck_i(sck), .csn_i(csn), .copi_i(copi), .cipo_o(cipo));

  always #10 i_ext_spi_clk_x = ~i_ext_spi_clk_x; // 20 ns period

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_cnt++;
      $display("MISMATCH at %0t: %s = %0h, expected %0h", $time, name, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // 16-bit Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] galois_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_byte(output byte_t b);
    int i;
    for (i = 0; i < BYTE_BITS; i++) begin
      lfsr_q = galois_step(lfsr_q); // One step per bit
      b = {b[BYTE_BITS-2:0], lfsr_q[0]};
    end
  endtask

  task automatic push_byte(input byte_t b);
    @(negedge i_ext_spi_clk_x);
    tx_data    = b;
    tx_enqueue = 1'b1;
    @(negedge i_ext_spi_clk_x);
    tx_enqueue = 1'b0;
  endtask

  task automatic pulse_dequeue();
    @(negedge i_ext_spi_clk_x);
    rx_dequeue = 1'b1;
    @(negedge i_ext_spi_clk_x);
    rx_dequeue = 1'b0; // rx_valid_o answers in this cycle
  endtask

  // Issues one command, waits for idle and checks framing and edge count
  task automatic run_command(input int tx, input int wt, input int rx);
    int limit;
    int cycles;
    limit  = (FRAME_BITS + 1 + BYTE_BITS * (tx + rx) + wt) * CLK_RATIO;
    cycles = 0;
    check_val("idle_o", idle, 1'b1);
    @(negedge i_ext_spi_clk_x);
    tx_len   = TX_LEN_W'(tx);
    rx_len   = RX_LEN_W'(rx);
    wait_cyc = WAIT_W'(wt);
    go       = 1'b1;
    @(negedge i_ext_spi_clk_x);
    go = 1'b0;
    check_val("idle_o", idle, 1'b0); // Busy the cycle after go
    while (!idle) begin
      @(negedge i_ext_spi_clk_x);
      cycles++;
      if (cycles > limit) begin
        $display("Transaction did not return to idle within %0d cycles", limit);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Idle timeout");
      end
    end
    check_val("csn_o", csn, 1'b1);
    check_val("sck_o rising edges", u_dev_model.rise_count(),
              BYTE_BITS * (tx + rx) + ((rx > 0) ? wt : 0));
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_values();
    check_val("csn_o", csn, 1'b1);
    check_val("sck_o", sck, 1'b0);
    check_val("copi_o", copi, 1'b0);
    check_val("idle_o", idle, 1'b1);
    check_val("tx_ready_o", tx_ready, 1'b1);
    check_val("rx_avail_o", rx_avail, 1'b0);
    check_val("rx_valid_o", rx_valid, 1'b0);
  endtask

  task automatic test_tx_only();
    byte_t sent [3];
    int i;
    u_dev_model.arm(0);
    for (i = 0; i < 3; i++) begin
      draw_byte(sent[i]);
      push_byte(sent[i]);
    end
    run_command(3, 0, 0);
    for (i = 0; i < 3; i++) check_val("copi byte", u_dev_model.rec_byte(i), sent[i]);
  endtask

  task automatic test_tx_wait_rx();
    byte_t sent;
    byte_t resp [2];
    int i;
    u_dev_model.arm(BYTE_BITS + 3); // CIPO after the TX byte and the wait bits
    draw_byte(sent);
    push_byte(sent);
    for (i = 0; i < 2; i++) begin
      draw_byte(resp[i]);
      u_dev_model.queue_byte(resp[i]);
    end
    run_command(1, 3, 2);
    check_val("copi byte", u_dev_model.rec_byte(0), sent);
    for (i = 0; i < 2; i++) begin
      check_val("rx_avail_o", rx_avail, 1'b1);
      pulse_dequeue();
      check_val("rx_valid_o", rx_valid, 1'b1);
      check_val("rx_data_o", rx_data, resp[i]);
    end
    check_val("rx_avail_o", rx_avail, 1'b0);
  endtask

  task automatic test_tx_underrun();
    byte_t sent;
    u_dev_model.arm(0);
    draw_byte(sent);
    push_byte(sent);
    run_command(2, 0, 0);
    check_val("copi byte", u_dev_model.rec_byte(0), sent);
    check_val("copi byte", u_dev_model.rec_byte(1), 8'h00); // Empty FIFO sends zeros
  endtask

  task automatic test_back_pressure();
    byte_t sent [FIFO_DEPTH + 1];
    int i;
    u_dev_model.arm(0);
    for (i = 0; i <= FIFO_DEPTH; i++) begin
      draw_byte(sent[i]);
      push_byte(sent[i]);
      check_val("tx_ready_o", tx_ready, (i + 1) < FIFO_DEPTH);
    end
    run_command(FIFO_DEPTH, 0, 0);
    for (i = 0; i < FIFO_DEPTH; i++) check_val("copi byte", u_dev_model.rec_byte(i), sent[i]);
    check_val("tx_ready_o", tx_ready, 1'b1);
    check_val("rx_avail_o", rx_avail, 1'b0);
    pulse_dequeue(); // Nothing to read
    check_val("rx_valid_o", rx_valid, 1'b0);
    @(negedge i_ext_spi_clk_x);
    check_val("rx_valid_o", rx_valid, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    i_ext_spi_clk_x = 1'b0;
    i_srst     = 1'b1;
    tx_data    = '0;
    tx_enqueue = 1'b0;
    rx_dequeue = 1'b0;
    go         = 1'b0;
    tx_len     = '0;
    rx_len     = '0;
    wait_cyc   = '0;
    lfsr_q     = 16'd3;
    fail_cnt   = 0;
    repeat (10) @(negedge i_ext_spi_clk_x);
    i_srst = 1'b0;
    test_reset_values();
    test_tx_only();
    test_tx_wait_rx();
    test_tx_underrun();
    test_back_pressure();
    if (fail_cnt == 0) $display("TEST RESULT: PASS");
    else $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Watchdog timeout");
  end

endmodule : spi_solo_tb
